/* dv/l2_cache_tb.sv */
`timescale 1ns/1ns
`include "l2_cache_cfg.svh"

module l2_cache_tb
    import l2_cache_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int RST_CYCLES     = 8;
    localparam int NUM_RANDOM     = 200;
    localparam int POOL_LINES     = 24;
    localparam int NUM_REQ        = 14 + NUM_RANDOM;
    // Write-back and refill of 5 cycles each plus the hit
    localparam int MISS_CYCLES    = 2 * 5 + 3;
    localparam int TIMEOUT_CYCLES = NUM_REQ * MISS_CYCLES * 2 + RST_CYCLES;
    localparam int LINE_ADDR_BITS = `L2_ADDR_BITS - OFFSET_BITS;

    logic        clk;
    logic        rst_n;
    logic        mem_read;
    logic        mem_write;
    l2_addr_t    mem_address;
    l2_line_t    mem_wdata;
    l2_line_t    mem_rdata;
    logic        mem_resp;
    logic        pmem_read;
    logic        pmem_write;
    l2_addr_t    pmem_address;
    l2_line_t    pmem_wdata;
    l2_line_t    pmem_rdata;
    logic        pmem_resp;
    logic [15:0] hit_count;
    logic [15:0] miss_count;
    int          reads;
    int          writes;

    int          data_errors;
    int          proto_errors;
    int          req_total;
    int          cycle_count;
    int          seed;
    l2_line_t    shadow [2 ** LINE_ADDR_BITS];
    // Last write-back seen on the memory port
    l2_addr_t    wb_addr;
    l2_line_t    wb_data;
    int          wb_reads;

    l2_cache DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .hit_count    (hit_count),
        .miss_count   (miss_count)
    );

    l2_pmem_model #(.DELAY(3)) u_pmem (
        .clk          (clk),
        .rst_n        (rst_n),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .read_count   (reads),
        .write_count  (writes)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // **********************************************************************
    // Protocol checks
    // **********************************************************************
    a_pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(pmem_read && pmem_write))
    else begin
        $display("Protocol error: pmem_read and pmem_write high together");
        proto_errors++;
    end

    a_pmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((pmem_read || pmem_write) && !pmem_resp) |=>
        (pmem_read == $past(pmem_read) && pmem_write == $past(pmem_write)
         && $stable(pmem_address)))
    else begin
        $display("Protocol error: memory request changed before pmem_resp");
        proto_errors++;
    end

    a_wdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (pmem_write && !pmem_resp) |=> $stable(pmem_wdata))
    else begin
        $display("Protocol error: pmem_wdata changed before pmem_resp");
        proto_errors++;
    end

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |=> !mem_resp)
    else begin
        $display("Protocol error: mem_resp high for two cycles");
        proto_errors++;
    end

    a_write_bound: assert property (@(posedge clk) disable iff (!rst_n)
        writes <= miss_count)
    else begin
        $display("Protocol error: more memory writes than misses");
        proto_errors++;
    end

    always @(negedge clk) begin
        if (pmem_write && pmem_resp) begin
            wb_addr  = pmem_address;
            wb_data  = pmem_wdata;
            wb_reads = reads;
        end
    end

    // Whole run is bounded by the worst case of every request
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // Same lane pattern the memory model starts with
    function automatic l2_line_t expected_fill(logic [LINE_ADDR_BITS-1:0] addr);
        l2_line_t line;
        for (int i = 0; i < 8; i++) begin
            line[i*16 +: 16] = {addr, 4'(i)} ^ 16'h5a3c;
        end
        return line;
    endfunction

    function automatic l2_addr_t line_address(l2_tag_t tag, l2_index_t index);
        l2_addr_t addr;
        addr.tag    = tag;
        addr.index  = index;
        addr.offset = '0;
        return addr;
    endfunction

    function automatic l2_line_t random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check_equal(string name, l2_line_t expected, l2_line_t actual);
        assert (actual === expected)
        else begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            data_errors++;
        end
    endtask

    task automatic expect_idle(string name);
        check_equal({name, " mem_resp"}, '0, mem_resp);
        check_equal({name, " pmem_read"}, '0, pmem_read);
        check_equal({name, " pmem_write"}, '0, pmem_write);
        check_equal({name, " hit_count"}, '0, hit_count);
        check_equal({name, " miss_count"}, '0, miss_count);
    endtask

    // One request held until mem_resp
    // Starts just after a rising edge so the next request follows back to back
    task automatic access(input logic is_write, input l2_addr_t addr,
                          input l2_line_t wdata, output l2_line_t rdata);
        mem_read    = !is_write;
        mem_write   = is_write;
        mem_address = addr;
        mem_wdata   = wdata;
        @(negedge clk);
        while (!mem_resp) begin
            @(negedge clk);
        end
        rdata = mem_rdata;
        req_total++;
        if (is_write) begin
            shadow[{addr.tag, addr.index}] = wdata;
        end
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic read_check(string name, l2_addr_t addr);
        l2_line_t data;
        access(1'b0, addr, '0, data);
        check_equal(name, shadow[{addr.tag, addr.index}], data);
    endtask

    // **********************************************************************
    // Tests
    // **********************************************************************
    task automatic cold_read_then_hit();
        l2_addr_t    addr;
        l2_line_t    data;
        int          r0;
        int          w0;
        logic [15:0] h0;
        logic [15:0] m0;
        addr = line_address(l2_tag_t'(1), l2_index_t'(0));
        r0 = reads;
        w0 = writes;
        h0 = hit_count;
        m0 = miss_count;
        access(1'b0, addr, '0, data);
        check_equal("cold_read data", expected_fill({addr.tag, addr.index}), data);
        check_equal("cold_read miss_count", m0 + 16'd1, miss_count);
        check_equal("cold_read hit_count", h0, hit_count);
        check_equal("cold_read pmem reads", r0 + 1, reads);
        check_equal("cold_read pmem writes", w0, writes);
        access(1'b0, addr, '0, data);
        check_equal("repeat_read data", expected_fill({addr.tag, addr.index}), data);
        check_equal("repeat_read hit_count", h0 + 16'd1, hit_count);
        check_equal("repeat_read miss_count", m0 + 16'd1, miss_count);
        check_equal("repeat_read pmem reads", r0 + 1, reads);
        check_equal("repeat_read pmem writes", w0, writes);
    endtask

    task automatic write_hit_readback();
        l2_addr_t    addr;
        l2_line_t    data;
        int          r0;
        int          w0;
        logic [15:0] h0;
        addr = line_address(l2_tag_t'(1), l2_index_t'(0));
        r0 = reads;
        w0 = writes;
        h0 = hit_count;
        access(1'b1, addr, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, data);
        check_equal("write_hit hit_count", h0 + 16'd1, hit_count);
        check_equal("write_hit pmem writes", w0, writes);
        check_equal("write_hit pmem reads", r0, reads);
        read_check("write_hit readback", addr);
    endtask

    // Nine tags in set 1 where the ninth evicts the first
    task automatic replace_in_full_set();
        l2_addr_t addr;
        l2_addr_t first;
        l2_line_t data;
        l2_line_t first_data;
        l2_line_t unused;
        int       w_start;
        int       r_before;
        w_start  = writes;
        r_before = 0;
        for (int k = 0; k < 9; k++) begin
            addr = line_address(l2_tag_t'(10'h100 + k), l2_index_t'(1));
            data = random_line();
            if (k == 0) begin
                first      = addr;
                first_data = data;
            end
            if (k == 8) begin
                r_before = reads;
            end
            access(1'b1, addr, data, unused);
        end
        check_equal("replacement pmem writes", w_start + 1, writes);
        check_equal("replacement wb address", first, wb_addr);
        check_equal("replacement wb data", first_data, wb_data);
        check_equal("replacement wb before refill", r_before, wb_reads);
        check_equal("replacement pmem reads", r_before + 1, reads);
        read_check("replacement reload", first);
    endtask

    task automatic random_mix();
        l2_addr_t pool [POOL_LINES];
        l2_addr_t addr;
        l2_line_t unused;
        int       pick;
        for (int k = 0; k < POOL_LINES; k++) begin
            pool[k] = line_address(l2_tag_t'(10'h200 + k), l2_index_t'(k % `L2_SETS));
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            pick        = $unsigned($random(seed)) % POOL_LINES;
            addr        = pool[pick];
            // Offset is ignored by the cache
            addr.offset = OFFSET_BITS'($random(seed));
            if ($random(seed) & 1) begin
                access(1'b1, addr, random_line(), unused);
            end else begin
                read_check("random_mix read", addr);
            end
        end
        check_equal("random_mix hit+miss", req_total, hit_count + miss_count);
    endtask

    initial begin
        seed         = 36633;
        data_errors  = 0;
        proto_errors = 0;
        req_total    = 0;
        wb_addr      = '0;
        wb_data      = '0;
        wb_reads     = 0;
        rst_n        = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_address  = '0;
        mem_wdata    = '0;
        for (int i = 0; i < 2 ** LINE_ADDR_BITS; i++) begin
            shadow[i] = expected_fill(LINE_ADDR_BITS'(i));
        end

        repeat (RST_CYCLES) begin
            @(negedge clk);
            expect_idle("reset");
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            expect_idle("after_reset");
        end
        @(posedge clk);
        #1;

        cold_read_then_hit();
        write_hit_readback();
        replace_in_full_set();
        random_mix();

        repeat (2) @(posedge clk);
        $display("Errors: %0d data, %0d protocol", data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : l2_cache_tb

/* dv/l2_pmem_model.sv */
`timescale 1ns/1ns
`include "l2_cache_cfg.svh"

module l2_pmem_model
    import l2_cache_pkg::*;
#(
    parameter int DELAY = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pmem_read,
    input  logic     pmem_write,
    input  l2_addr_t pmem_address,
    input  l2_line_t pmem_wdata,
    output l2_line_t pmem_rdata,
    output logic     pmem_resp,
    output int       read_count,
    output int       write_count
);

    localparam int LINE_ADDR_BITS = `L2_ADDR_BITS - OFFSET_BITS;
    localparam int NUM_LINES      = 2 ** LINE_ADDR_BITS;

    l2_line_t                  mem [NUM_LINES];
    logic [LINE_ADDR_BITS-1:0] line_addr;
    int                        wait_count;

    // Each 16-bit lane mixes the line address with its lane number
    function automatic l2_line_t fill_pattern(logic [LINE_ADDR_BITS-1:0] addr);
        l2_line_t line;
        for (int i = 0; i < 8; i++) begin
            line[i*16 +: 16] = {addr, 4'(i)} ^ 16'h5a3c;
        end
        return line;
    endfunction

    initial begin
        for (int i = 0; i < NUM_LINES; i++) begin
            mem[i] = fill_pattern(LINE_ADDR_BITS'(i));
        end
    end

    assign line_addr = {pmem_address.tag, pmem_address.index};

    // Respond DELAY cycles after a request shows up
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_count  <= 0;
            pmem_resp   <= 1'b0;
            pmem_rdata  <= '0;
            read_count  <= 0;
            write_count <= 0;
        end else begin
            pmem_resp <= 1'b0;
            if ((pmem_read || pmem_write) && !pmem_resp) begin
                if (wait_count == DELAY - 1) begin
                    wait_count <= 0;
                    pmem_resp  <= 1'b1;
                    if (pmem_write) begin
                        mem[line_addr] <= pmem_wdata;
                        write_count    <= write_count + 1;
                    end else begin
                        pmem_rdata <= mem[line_addr];
                        read_count <= read_count + 1;
                    end
                end else begin
                    wait_count <= wait_count + 1;
                end
            end
        end
    end

endmodule : l2_pmem_model

/* filelist.f */
+incdir+hw
hw/l2_cache_pkg.sv
hw/l2_line_array.sv
hw/l2_way.sv
hw/l2_plru_tree.sv
hw/l2_way_select.sv
hw/l2_cache_control.sv
hw/l2_cache.sv
dv/l2_pmem_model.sv
dv/l2_cache_tb.sv

/* hw/l2_cache.sv */
`timescale 1ns/1ns
`include "l2_cache_cfg.svh"

module l2_cache
    import l2_cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read,
    input  logic        mem_write,
    input  l2_addr_t    mem_address,
    input  l2_line_t    mem_wdata,
    output l2_line_t    mem_rdata,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write,
    output l2_addr_t    pmem_address,
    output l2_line_t    pmem_wdata,
    input  l2_line_t    pmem_rdata,
    input  logic        pmem_resp,
    output logic [15:0] hit_count,
    output logic [15:0] miss_count
);

    l2_way_ctl_t  way_ctl  [`L2_WAYS];
    l2_way_stat_t way_stat [`L2_WAYS];
    logic         hit;
    l2_way_idx_t  hit_way;
    l2_way_idx_t  victim_way;
    l2_tag_t      victim_tag;
    l2_line_t     victim_line;
    logic         victim_valid;
    logic         victim_dirty;
    logic         touch;
    l2_way_idx_t  touch_way;

    l2_cache_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_resp     (mem_resp),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .way_ctl      (way_ctl),
        .touch        (touch),
        .touch_way    (touch_way),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .hit_count    (hit_count),
        .miss_count   (miss_count)
    );

    // All ways look at the same set
    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        l2_way u_way (
            .clk        (clk),
            .rst_n      (rst_n),
            .index      (mem_address.index),
            .tag        (mem_address.tag),
            .ctl        (way_ctl[w]),
            .fill_line  (pmem_rdata),
            .write_line (mem_wdata),
            .stat       (way_stat[w])
        );
    end

    l2_way_select u_select (
        .stat         (way_stat),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_line     (mem_rdata),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty)
    );

    l2_plru_tree u_plru (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (mem_address.index),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

endmodule : l2_cache

/* hw/l2_cache_cfg.svh */
`ifndef L2_CACHE_CFG_SVH
`define L2_CACHE_CFG_SVH

// *********************************************************************
// Cache geometry
// *********************************************************************

// Associativity
`define L2_WAYS 8

`define L2_SETS 4

// Line width in bits, 16 bytes
`define L2_LINE_BITS 128

// Byte address width of the processor
`define L2_ADDR_BITS 16

// One node per internal vertex of the way tree
`define L2_TREE_BITS 7

`endif

/* hw/l2_cache_control.sv */
`timescale 1ns/1ns
`include "l2_cache_cfg.svh"

module l2_cache_control
    import l2_cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read,
    input  logic        mem_write,
    input  l2_addr_t    mem_address,
    output logic        mem_resp,
    input  logic        hit,
    input  l2_way_idx_t hit_way,
    input  l2_way_idx_t victim_way,
    input  l2_tag_t     victim_tag,
    input  l2_line_t    victim_line,
    input  logic        victim_valid,
    input  logic        victim_dirty,
    output l2_way_ctl_t way_ctl [`L2_WAYS],
    output logic        touch,
    output l2_way_idx_t touch_way,
    output logic        pmem_read,
    output logic        pmem_write,
    output l2_addr_t    pmem_address,
    output l2_line_t    pmem_wdata,
    input  logic        pmem_resp,
    output logic [15:0] hit_count,
    output logic [15:0] miss_count
);

    l2_state_e state_q;
    l2_state_e state_d;
    logic      req;
    logic      write_hit;
    logic      fill_done;
    logic      enter_wb;
    logic      enter_fetch;
    logic      hit_inc;
    logic      miss_inc;
    // Request already counted as a miss
    logic      refill_q;

    // Both strobes together is not a request
    assign req       = mem_read ^ mem_write;
    assign touch_way = hit_way;

    // *********************************************************************
    // Next state and outputs
    // *********************************************************************
    always_comb begin
        state_d     = state_q;
        mem_resp    = 1'b0;
        touch       = 1'b0;
        write_hit   = 1'b0;
        fill_done   = 1'b0;
        enter_wb    = 1'b0;
        enter_fetch = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        hit_inc     = 1'b0;
        miss_inc    = 1'b0;
        case (state_q)
            process_request: begin
                if (req && hit) begin
                    mem_resp  = 1'b1;
                    touch     = 1'b1;
                    write_hit = mem_write;
                    hit_inc   = !refill_q;
                    state_d   = buffer;
                end else if (req) begin
                    miss_inc = 1'b1;
                    if (victim_valid && victim_dirty) begin
                        enter_wb = 1'b1;
                        state_d  = write_back;
                    end else begin
                        enter_fetch = 1'b1;
                        state_d     = fetch_cline;
                    end
                end
            end
            write_back: begin
                pmem_write = 1'b1;
                if (pmem_resp) begin
                    enter_fetch = 1'b1;
                    state_d     = fetch_cline;
                end
            end
            fetch_cline: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    fill_done = 1'b1;
                    state_d   = process_request;
                end
            end
            buffer: begin
                state_d = process_request;
            end
            default: begin
                state_d = process_request;
            end
        endcase
    end

    // Per-way commands
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            way_ctl[w] = '0;
            if (write_hit && hit_way == l2_way_idx_t'(w)) begin
                way_ctl[w].load_data = 1'b1;
                way_ctl[w].set_dirty = 1'b1;
                way_ctl[w].data_src  = DATA_WRITE;
            end
            if (fill_done && victim_way == l2_way_idx_t'(w)) begin
                way_ctl[w].load_tag    = 1'b1;
                way_ctl[w].load_data   = 1'b1;
                way_ctl[w].clear_dirty = 1'b1;
                way_ctl[w].data_src    = DATA_PMEM;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= process_request;
            refill_q   <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state_q <= state_d;
            if (miss_inc) begin
                refill_q <= 1'b1;
            end else if (mem_resp) begin
                refill_q <= 1'b0;
            end
            if (hit_inc) begin
                hit_count <= hit_count + 16'd1;
            end
            if (miss_inc) begin
                miss_count <= miss_count + 16'd1;
            end
        end
    end

    // Memory-side address and data, line aligned
    always_ff @(posedge clk) begin
        if (enter_wb) begin
            pmem_address <= '{tag: victim_tag, index: mem_address.index, offset: '0};
            pmem_wdata   <= victim_line;
        end else if (enter_fetch) begin
            pmem_address <= '{tag: mem_address.tag, index: mem_address.index, offset: '0};
        end
    end

endmodule : l2_cache_control

/* hw/l2_cache_pkg.sv */
`include "l2_cache_cfg.svh"

package l2_cache_pkg;

    localparam int INDEX_BITS  = $clog2(`L2_SETS);
    localparam int OFFSET_BITS = $clog2(`L2_LINE_BITS / 8);
    localparam int TAG_BITS    = `L2_ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int WAY_BITS    = $clog2(`L2_WAYS);

    typedef logic [TAG_BITS-1:0]   l2_tag_t;
    typedef logic [INDEX_BITS-1:0] l2_index_t;
    typedef logic [WAY_BITS-1:0]   l2_way_idx_t;

    // Offset bits are ignored, the cache works on whole lines
    typedef struct packed {
        l2_tag_t                tag;
        l2_index_t              index;
        logic [OFFSET_BITS-1:0] offset;
    } l2_addr_t;

    typedef logic [`L2_LINE_BITS-1:0] l2_line_t;

    typedef struct packed {
        l2_tag_t tag;
        logic    valid;
        logic    dirty;
    } l2_tag_entry_t;

    typedef enum logic {
        DATA_PMEM,
        DATA_WRITE
    } l2_data_src_e;

    typedef struct packed {
        logic         load_tag;
        logic         load_data;
        logic         set_dirty;
        logic         clear_dirty;
        l2_data_src_e data_src;
    } l2_way_ctl_t;

    typedef struct packed {
        logic     hit;
        logic     valid;
        logic     dirty;
        l2_tag_t  tag;
        l2_line_t line;
    } l2_way_stat_t;

    typedef enum logic [1:0] {
        process_request,
        write_back,
        fetch_cline,
        buffer
    } l2_state_e;

endpackage : l2_cache_pkg

/* hw/l2_line_array.sv */
`timescale 1ns/1ns
`include "l2_cache_cfg.svh"

module l2_line_array
    import l2_cache_pkg::*;
#(
    parameter type entry_t = l2_line_t
) (
    input  logic      clk,
    input  logic      rst_n,
    input  l2_index_t index,
    input  logic      load,
    input  entry_t    wdata,
    output entry_t    rdata
);

    entry_t mem [`L2_SETS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `L2_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (load) begin
            mem[index] <= wdata;
        end
    end

    // Read is combinational
    assign rdata = mem[index];

endmodule : l2_line_array

/* hw/l2_plru_tree.sv */
`timescale 1ns/1ns
`include "l2_cache_cfg.svh"

module l2_plru_tree
    import l2_cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  l2_index_t   index,
    input  logic        touch,
    input  l2_way_idx_t touch_way,
    output l2_way_idx_t victim_way
);

    // Heap order, node n has children 2n+1 (lower) and 2n+2 (upper)
    logic [`L2_TREE_BITS-1:0] tree_q [`L2_SETS];
    logic [`L2_TREE_BITS-1:0] cur;
    logic [`L2_TREE_BITS-1:0] upd;

    assign cur = tree_q[index];

    // *********************************************************************
    // Victim walk from the root
    // *********************************************************************
    always_comb begin
        int node;
        node       = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            victim_way[WAY_BITS-1-lvl] = cur[node];
            node = 2 * node + 1 + int'(cur[node]);
        end
    end

    // Point every node on the touched path away from it
    always_comb begin
        int node;
        node = 0;
        upd  = cur;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            upd[node] = ~touch_way[WAY_BITS-1-lvl];
            node = 2 * node + 1 + int'(touch_way[WAY_BITS-1-lvl]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[index] <= upd;
        end
    end

endmodule : l2_plru_tree

/* hw/l2_way.sv */
`timescale 1ns/1ns

module l2_way
    import l2_cache_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  l2_index_t    index,
    input  l2_tag_t      tag,
    input  l2_way_ctl_t  ctl,
    input  l2_line_t     fill_line,
    input  l2_line_t     write_line,
    output l2_way_stat_t stat
);

    l2_tag_entry_t entry_q;
    l2_tag_entry_t entry_d;
    l2_line_t      line_q;
    l2_line_t      line_d;
    logic          load_entry;

    // Next tag entry from the controller commands
    always_comb begin
        entry_d = entry_q;
        if (ctl.load_tag) begin
            entry_d.tag   = tag;
            entry_d.valid = 1'b1;
        end
        if (ctl.set_dirty) begin
            entry_d.dirty = 1'b1;
        end else if (ctl.clear_dirty) begin
            entry_d.dirty = 1'b0;
        end
    end

    assign load_entry = ctl.load_tag | ctl.set_dirty | ctl.clear_dirty;
    assign line_d     = (ctl.data_src == DATA_WRITE) ? write_line : fill_line;

    l2_line_array #(.entry_t(l2_tag_entry_t)) u_tag_array (
        .clk   (clk),
        .rst_n (rst_n),
        .index (index),
        .load  (load_entry),
        .wdata (entry_d),
        .rdata (entry_q)
    );

    l2_line_array #(.entry_t(l2_line_t)) u_data_array (
        .clk   (clk),
        .rst_n (rst_n),
        .index (index),
        .load  (ctl.load_data),
        .wdata (line_d),
        .rdata (line_q)
    );

    assign stat.hit   = entry_q.valid && (entry_q.tag == tag);
    assign stat.valid = entry_q.valid;
    assign stat.dirty = entry_q.dirty;
    assign stat.tag   = entry_q.tag;
    assign stat.line  = line_q;

endmodule : l2_way

/* hw/l2_way_select.sv */
`timescale 1ns/1ns
`include "l2_cache_cfg.svh"

module l2_way_select
    import l2_cache_pkg::*;
(
    input  l2_way_stat_t stat [`L2_WAYS],
    input  l2_way_idx_t  victim_way,
    output logic         hit,
    output l2_way_idx_t  hit_way,
    output l2_line_t     hit_line,
    output l2_tag_t      victim_tag,
    output l2_line_t     victim_line,
    output logic         victim_valid,
    output logic         victim_dirty
);

    // At most one way hits, so the vector is one-hot
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (stat[w].hit) begin
                hit     = 1'b1;
                hit_way = l2_way_idx_t'(w);
            end
        end
    end

    assign hit_line = stat[hit_way].line;

    // Victim view chosen by the tree
    assign victim_tag   = stat[victim_way].tag;
    assign victim_line  = stat[victim_way].line;
    assign victim_valid = stat[victim_way].valid;
    assign victim_dirty = stat[victim_way].dirty;

endmodule : l2_way_select
